/* flist.f */
+incdir+include
rtl/wbx_pkg.sv
rtl/wb_if.sv
rtl/wb_priority_arbiter.sv
rtl/wb_bus_delay.sv
rtl/wb_addr_decode.sv
rtl/wb_return_path.sv
rtl/block_ram.sv
rtl/board_io.sv
rtl/wbx_interconnect.sv
sim/tb_clkgen.sv
sim/wbx_tb.sv

/* include/wbx_params.svh */
/*
 * Bus widths, address map and board I/O register offsets
 */
`ifndef WBX_PARAMS_SVH
`define WBX_PARAMS_SVH

// Bus widths
`define WBX_DATA_W	32
`define WBX_ADDR_W	26
`define WBX_SEL_W	4

// Block RAM, 1K words at word address 0x400
`define WBX_BRAM_AW	10
`define WBX_BRAM_BASE	26'h0000400

// Board I/O, 16 words at the bottom of the map
`define WBX_IO_BASE	26'h0000000
`define WBX_IO_AW	4

// Top address bit selects the external RAM
`define WBX_EXTRAM_BIT	25

// Board I/O contents
`define WBX_LED_W	4
`define WBX_IO_LED	4'h0
`define WBX_IO_SW	4'h1
`define WBX_IO_ERRADDR	4'h2

`endif

/* rtl/block_ram.sv */
/*
 * 1K-word block RAM slave with byte-lane writes
 */
`timescale 1ns/10ps
`default_nettype none

`include "wbx_params.svh"

module block_ram import wbx_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_stb,
	input wire logic i_we,
	input wire bram_addr_t i_addr,
	input wire wb_data_t i_data,
	input wire wb_sel_t i_sel,
	output logic o_ack,
	output wb_data_t o_data
);

	wb_data_t mem [0:(1 << `WBX_BRAM_AW)-1];

	// Byte-lane write, read-first port
	always_ff @(posedge i_clk)
	begin
		if (i_stb && i_we)
		begin
			for (int i = 0; i < `WBX_SEL_W; i++)
			begin
				if (i_sel[i])
					mem[i_addr][8*i +: 8] <= i_data[8*i +: 8];
			end
		end
		o_data <= mem[i_addr];
	end

	// Every strobe answered next cycle
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_ack <= 1'b0;
		else
			o_ack <= i_stb;
	end

endmodule

`default_nettype wire

/* rtl/board_io.sv */
/*
 * Board register slave with LEDs, switches and bus-error address
 */
`timescale 1ns/10ps
`default_nettype none

`include "wbx_params.svh"

module board_io import wbx_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_stb,
	input wire logic i_we,
	input wire logic [`WBX_IO_AW-1:0] i_addr,
	input wire wb_data_t i_data,
	input wire led_t i_sw,
	input wire wb_addr_t i_err_addr,
	output logic o_ack,
	output wb_data_t o_data,
	output led_t o_led
);

	led_t sw_meta;
	led_t sw_sync;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_ack <= 1'b0;
			o_led <= '0;
			sw_meta <= '0;
			sw_sync <= '0;
		end
		else
		begin
			o_ack <= i_stb;
			// Switches come from the pins, two-flop synchronizer
			sw_meta <= i_sw;
			sw_sync <= sw_meta;
			// Only the LED register is writable
			if (i_stb && i_we && (i_addr == `WBX_IO_LED))
				o_led <= i_data[`WBX_LED_W-1:0];
		end
	end

	// Readback mux
	always_ff @(posedge i_clk)
	begin
		case (i_addr)
		`WBX_IO_LED: o_data <= wb_data_t'(o_led);
		`WBX_IO_SW: o_data <= wb_data_t'(sw_sync);
		`WBX_IO_ERRADDR: o_data <= wb_data_t'(i_err_addr);
		default: o_data <= '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/wb_addr_decode.sv */
/*
 * Slave address decoder and default slave for unmapped accesses
 */
`timescale 1ns/10ps
`default_nettype none

`include "wbx_params.svh"

module wb_addr_decode import wbx_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	input wire logic i_cyc,
	input wire logic i_stb,
	input wire wb_addr_t i_addr,
	output logic o_io_stb,
	output logic o_bram_stb,
	output logic o_ram_stb,
	output logic o_none_ack
);

	localparam wb_addr_t BRAM_BASE = `WBX_BRAM_BASE;
	localparam wb_addr_t IO_BASE = `WBX_IO_BASE;

	slave_sel_e slave_sel;
	logic req;

	// Map check, external RAM bit wins over everything
	always_comb
	begin
		if (i_addr[`WBX_EXTRAM_BIT])
			slave_sel = SEL_EXTRAM;
		else if (i_addr[`WBX_ADDR_W-1:`WBX_BRAM_AW]
				== BRAM_BASE[`WBX_ADDR_W-1:`WBX_BRAM_AW])
			slave_sel = SEL_BRAM;
		else if (i_addr[`WBX_ADDR_W-1:`WBX_IO_AW]
				== IO_BASE[`WBX_ADDR_W-1:`WBX_IO_AW])
			slave_sel = SEL_IO;
		else
			slave_sel = SEL_NONE;
	end

	assign req = i_cyc && i_stb;

	// Strobes straight through to the slaves
	assign o_io_stb = req && (slave_sel == SEL_IO);
	assign o_bram_stb = req && (slave_sel == SEL_BRAM);
	assign o_ram_stb = req && (slave_sel == SEL_EXTRAM);

	// Default slave answers a cycle later, same as the on-chip slaves
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_none_ack <= 1'b0;
		else
			o_none_ack <= req && (slave_sel == SEL_NONE);
	end

endmodule

`default_nettype wire

/* rtl/wb_bus_delay.sv */
/*
 * One-cycle registered Wishbone request stage
 */
`timescale 1ns/10ps
`default_nettype none

module wb_bus_delay import wbx_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	wb_if.slave up,
	wb_if.master down
);

	logic r_cyc;
	logic r_stb;
	logic r_we;
	wb_addr_t r_addr;
	wb_data_t r_data;
	wb_sel_t r_sel;

	// Held request blocks a new one
	assign up.stall = r_stb && down.stall;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			r_cyc <= 1'b0;
			r_stb <= 1'b0;
		end
		else
		begin
			r_cyc <= up.cyc;
			// Abandoned cycle clears the pending strobe
			if (!up.cyc)
				r_stb <= 1'b0;
			else if (!up.stall)
				r_stb <= up.stb;
		end
	end

	// Payload follows the strobe, frozen while stalled
	always_ff @(posedge i_clk)
	begin
		if (!up.stall)
		begin
			r_we <= up.we;
			r_addr <= up.addr;
			r_data <= up.data;
			r_sel <= up.sel;
		end
	end

	// Downstream drops at once when the master releases cyc
	assign down.cyc = r_cyc && up.cyc;
	assign down.stb = r_stb && up.cyc;
	assign down.we = r_we;
	assign down.addr = r_addr;
	assign down.data = r_data;
	assign down.sel = r_sel;

	// Return side is not delayed
	assign up.ack = down.ack;
	assign up.err = down.err;
	assign up.rdata = down.rdata;

endmodule

`default_nettype wire

/* rtl/wb_if.sv */
/*
 * Pipelined Wishbone bundle with master and slave modports
 */
`timescale 1ns/10ps
`default_nettype none

interface wb_if import wbx_pkg::*; ();

	// Request side, driven by the master
	logic cyc;
	logic stb;
	logic we;
	wb_addr_t addr;
	wb_data_t data;
	wb_sel_t sel;

	// Response side, driven by the slave
	logic ack;
	logic stall;
	logic err;
	wb_data_t rdata;

	modport master (output cyc, stb, we, addr, data, sel,
		input ack, stall, err, rdata);
	modport slave (input cyc, stb, we, addr, data, sel,
		output ack, stall, err, rdata);

endinterface

`default_nettype wire

/* rtl/wb_priority_arbiter.sv */
/*
 * Two-master fixed-priority Wishbone arbiter, CPU first
 */
`timescale 1ns/10ps
`default_nettype none

module wb_priority_arbiter import wbx_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	wb_if.slave cpu,
	wb_if.slave host,
	wb_if.master bus
);

	// Bus held by an owner since last cycle
	logic r_busy;
	logic r_owner_cpu;
	logic sel_cpu;

	// Idle bus goes to the CPU if it asks, or if nobody else does
	assign sel_cpu = r_busy ? r_owner_cpu : (cpu.cyc || !host.cyc);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			r_busy <= 1'b0;
			r_owner_cpu <= 1'b1;
		end
		else
		begin
			// Ownership lasts until the owner drops cyc
			r_busy <= bus.cyc;
			r_owner_cpu <= sel_cpu;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request mux
	//////////////////////////////////////////////////////////////////////
	assign bus.cyc = sel_cpu ? cpu.cyc : host.cyc;
	assign bus.stb = sel_cpu ? cpu.stb : host.stb;
	assign bus.we = sel_cpu ? cpu.we : host.we;
	assign bus.addr = sel_cpu ? cpu.addr : host.addr;
	assign bus.data = sel_cpu ? cpu.data : host.data;
	assign bus.sel = sel_cpu ? cpu.sel : host.sel;

	//////////////////////////////////////////////////////////////////////
	// Responses, only to the owner
	//////////////////////////////////////////////////////////////////////
	// Stale responses after cyc falls are dropped
	assign cpu.ack = sel_cpu && cpu.cyc && bus.ack;
	assign cpu.err = sel_cpu && cpu.cyc && bus.err;
	assign host.ack = !sel_cpu && host.cyc && bus.ack;
	assign host.err = !sel_cpu && host.cyc && bus.err;

	// Read data shared, qualified by ack
	assign cpu.rdata = bus.rdata;
	assign host.rdata = bus.rdata;

	// Losing master sees a permanent stall
	assign cpu.stall = !sel_cpu || bus.stall;
	assign host.stall = sel_cpu || bus.stall;

endmodule

`default_nettype wire

/* rtl/wb_return_path.sv */
/*
 * Registered response merge, bus-error detection, error-address capture
 */
`timescale 1ns/10ps
`default_nettype none

`include "wbx_params.svh"

module wb_return_path import wbx_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	wb_if.slave bus,
	input wire logic i_io_ack,
	input wire wb_data_t i_io_data,
	input wire logic i_bram_ack,
	input wire wb_data_t i_bram_data,
	input wire logic i_ram_ack,
	input wire wb_data_t i_ram_data,
	input wire logic i_ram_err,
	input wire logic i_ram_stall,
	input wire logic i_none_ack,
	output wb_addr_t o_err_addr
);

	logic [3:0] resp;
	logic multi_resp;
	logic err_now;
	logic ack_now;
	logic r_ack;
	logic r_err;
	wb_data_t r_data;
	wb_addr_t r_addr_d;

	// One bit per responder
	assign resp = {i_ram_ack | i_ram_err, i_bram_ack, i_io_ack, i_none_ack};
	// More than one bit set
	assign multi_resp = (resp & (resp - 4'd1)) != 4'd0;
	assign err_now = multi_resp || i_none_ack || i_ram_err;
	assign ack_now = (|resp) && !err_now;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			r_ack <= 1'b0;
			r_err <= 1'b0;
			o_err_addr <= '0;
		end
		else
		begin
			r_ack <= bus.cyc && ack_now;
			r_err <= bus.cyc && err_now;
			// Address of the request that just failed
			if (bus.cyc && err_now)
				o_err_addr <= r_addr_d;
		end
	end

	// Read data, external RAM first
	always_ff @(posedge i_clk)
	begin
		if (i_ram_ack)
			r_data <= i_ram_data;
		else if (i_bram_ack)
			r_data <= i_bram_data;
		else
			r_data <= i_io_data;
	end

	// Address one cycle behind, lines up with single-cycle slaves
	always_ff @(posedge i_clk)
	begin
		if (bus.stb && !bus.stall)
			r_addr_d <= bus.addr;
	end

	assign bus.ack = r_ack;
	assign bus.err = r_err;
	assign bus.rdata = r_data;
	// Only the external RAM can stall
	assign bus.stall = bus.stb && bus.addr[`WBX_EXTRAM_BIT] && i_ram_stall;

endmodule

`default_nettype wire

/* rtl/wbx_interconnect.sv */
/*
 * Bus fabric top with two masters, block RAM, board I/O, external RAM port
 */
`timescale 1ns/10ps
`default_nettype none

`include "wbx_params.svh"

module wbx_interconnect import wbx_pkg::*; (
	input wire logic i_clk,
	input wire logic i_rst_n,
	// CPU master, priority port
	input wire logic i_cpu_cyc,
	input wire logic i_cpu_stb,
	input wire logic i_cpu_we,
	input wire wb_addr_t i_cpu_addr,
	input wire wb_data_t i_cpu_data,
	input wire wb_sel_t i_cpu_sel,
	output logic o_cpu_ack,
	output logic o_cpu_stall,
	output logic o_cpu_err,
	output wb_data_t o_cpu_data,
	// Host master
	input wire logic i_host_cyc,
	input wire logic i_host_stb,
	input wire logic i_host_we,
	input wire wb_addr_t i_host_addr,
	input wire wb_data_t i_host_data,
	input wire wb_sel_t i_host_sel,
	output logic o_host_ack,
	output logic o_host_stall,
	output logic o_host_err,
	output wb_data_t o_host_data,
	// External RAM
	output logic o_ram_cyc,
	output logic o_ram_stb,
	output logic o_ram_we,
	output wb_addr_t o_ram_addr,
	output wb_data_t o_ram_wdata,
	output wb_sel_t o_ram_sel,
	input wire logic i_ram_ack,
	input wire logic i_ram_stall,
	input wire wb_data_t i_ram_rdata,
	input wire logic i_ram_err,
	// Board
	input wire led_t i_sw,
	output led_t o_led
);

	wb_if cpu_bus ();
	wb_if host_bus ();
	wb_if arb_bus ();
	wb_if fab_bus ();

	logic io_stb, io_ack, bram_stb, bram_ack, none_ack;
	wb_data_t io_data, bram_data;
	wb_addr_t err_addr;

	//////////////////////////////////////////////////////////////////////
	// Master ports onto their bundles
	//////////////////////////////////////////////////////////////////////
	assign cpu_bus.cyc = i_cpu_cyc;
	assign cpu_bus.stb = i_cpu_stb;
	assign cpu_bus.we = i_cpu_we;
	assign cpu_bus.addr = i_cpu_addr;
	assign cpu_bus.data = i_cpu_data;
	assign cpu_bus.sel = i_cpu_sel;
	assign o_cpu_ack = cpu_bus.ack;
	assign o_cpu_stall = cpu_bus.stall;
	assign o_cpu_err = cpu_bus.err;
	assign o_cpu_data = cpu_bus.rdata;

	assign host_bus.cyc = i_host_cyc;
	assign host_bus.stb = i_host_stb;
	assign host_bus.we = i_host_we;
	assign host_bus.addr = i_host_addr;
	assign host_bus.data = i_host_data;
	assign host_bus.sel = i_host_sel;
	assign o_host_ack = host_bus.ack;
	assign o_host_stall = host_bus.stall;
	assign o_host_err = host_bus.err;
	assign o_host_data = host_bus.rdata;

	//////////////////////////////////////////////////////////////////////
	// Fabric
	//////////////////////////////////////////////////////////////////////
	wb_priority_arbiter u_arb (.i_clk, .i_rst_n,
		.cpu(cpu_bus), .host(host_bus), .bus(arb_bus));

	// Extra register to break the arbiter timing path
	wb_bus_delay u_delay (.i_clk, .i_rst_n, .up(arb_bus), .down(fab_bus));

	wb_addr_decode u_dec (.i_clk, .i_rst_n,
		.i_cyc(fab_bus.cyc), .i_stb(fab_bus.stb), .i_addr(fab_bus.addr),
		.o_io_stb(io_stb), .o_bram_stb(bram_stb), .o_ram_stb(o_ram_stb),
		.o_none_ack(none_ack));

	wb_return_path u_ret (.i_clk, .i_rst_n, .bus(fab_bus),
		.i_io_ack(io_ack), .i_io_data(io_data),
		.i_bram_ack(bram_ack), .i_bram_data(bram_data),
		.i_ram_ack, .i_ram_data(i_ram_rdata), .i_ram_err, .i_ram_stall,
		.i_none_ack(none_ack), .o_err_addr(err_addr));

	//////////////////////////////////////////////////////////////////////
	// Slaves
	//////////////////////////////////////////////////////////////////////
	block_ram u_bram (.i_clk, .i_rst_n, .i_stb(bram_stb), .i_we(fab_bus.we),
		.i_addr(fab_bus.addr[`WBX_BRAM_AW-1:0]), .i_data(fab_bus.data),
		.i_sel(fab_bus.sel), .o_ack(bram_ack), .o_data(bram_data));

	board_io u_io (.i_clk, .i_rst_n, .i_stb(io_stb), .i_we(fab_bus.we),
		.i_addr(fab_bus.addr[`WBX_IO_AW-1:0]), .i_data(fab_bus.data),
		.i_sw, .i_err_addr(err_addr), .o_ack(io_ack), .o_data(io_data),
		.o_led);

	// External RAM request straight off the delayed bus
	assign o_ram_cyc = fab_bus.cyc;
	assign o_ram_we = fab_bus.we;
	assign o_ram_addr = fab_bus.addr;
	assign o_ram_wdata = fab_bus.data;
	assign o_ram_sel = fab_bus.sel;

endmodule

`default_nettype wire

/* rtl/wbx_pkg.sv */
/*
 * Shared bus vector types and slave-select encoding
 */
`default_nettype none

`include "wbx_params.svh"

package wbx_pkg;

	// Bus field vectors
	typedef logic [`WBX_DATA_W-1:0] wb_data_t;
	typedef logic [`WBX_ADDR_W-1:0] wb_addr_t;
	typedef logic [`WBX_SEL_W-1:0] wb_sel_t;

	// Slave-local vectors
	typedef logic [`WBX_BRAM_AW-1:0] bram_addr_t;
	typedef logic [`WBX_LED_W-1:0] led_t;

	// Decoder result
	typedef enum logic [1:0] {
		SEL_NONE,
		SEL_IO,
		SEL_BRAM,
		SEL_EXTRAM
	} slave_sel_e;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/bash
# Build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module wbx_tb -o wbx_sim \
	&& ./obj_dir/wbx_sim \
	|| exit 1

/* sim/tb_clkgen.sv */
/*
 * Testbench clock and reset source
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);

	// 10 ns period
	initial
	begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// Reset held for 5 cycles
	initial
	begin
		o_rst_n = 1'b0;
		repeat (5) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* sim/wbx_tb.sv */
/*
 * Table-driven testbench for the bus interconnect, with external RAM model
 */
`timescale 1ns/10ps
`default_nettype none

`include "wbx_params.svh"

module wbx_tb import wbx_pkg::*; ();

	// Row flags
	localparam int F_RAM_ERR = 0;
	localparam int F_STALL = 1;
	localparam int F_SPUR = 2;
	localparam int F_LED = 3;
	localparam int F_CAP = 4;
	localparam int TMO = 50;

	typedef struct packed {
		logic host;
		logic we;
		wb_addr_t addr;
		wb_data_t data;
		wb_sel_t sel;
		logic exp_err;
		wb_data_t exp_data;
		logic [4:0] flags;
	} row_t;

	logic clk, rst_n;
	logic cpu_cyc, cpu_stb, cpu_we, cpu_ack, cpu_stall, cpu_err;
	logic host_cyc, host_stb, host_we, host_ack, host_stall, host_err;
	wb_addr_t cpu_addr, host_addr, ram_addr, cap_addr;
	wb_data_t cpu_data, host_data, cpu_rdata, host_rdata;
	wb_data_t ram_wdata, ram_rdata, cap_data;
	wb_sel_t cpu_sel, host_sel, ram_sel, cap_sel;
	logic ram_cyc, ram_stb, ram_we, ram_ack, ram_stall, ram_err, cap_we;
	led_t sw, led;

	// External RAM model state
	logic busy, spur_arm, spur_d, err_mode;
	logic [1:0] cnt;
	int stall_left;
	logic [31:0] rng;
	row_t rows[$];

	tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

	wbx_interconnect uut (.i_clk(clk), .i_rst_n(rst_n),
		.i_cpu_cyc(cpu_cyc), .i_cpu_stb(cpu_stb), .i_cpu_we(cpu_we),
		.i_cpu_addr(cpu_addr), .i_cpu_data(cpu_data), .i_cpu_sel(cpu_sel),
		.o_cpu_ack(cpu_ack), .o_cpu_stall(cpu_stall), .o_cpu_err(cpu_err),
		.o_cpu_data(cpu_rdata),
		.i_host_cyc(host_cyc), .i_host_stb(host_stb), .i_host_we(host_we),
		.i_host_addr(host_addr), .i_host_data(host_data), .i_host_sel(host_sel),
		.o_host_ack(host_ack), .o_host_stall(host_stall), .o_host_err(host_err),
		.o_host_data(host_rdata),
		.o_ram_cyc(ram_cyc), .o_ram_stb(ram_stb), .o_ram_we(ram_we),
		.o_ram_addr(ram_addr), .o_ram_wdata(ram_wdata), .o_ram_sel(ram_sel),
		.i_ram_ack(ram_ack), .i_ram_stall(ram_stall), .i_ram_rdata(ram_rdata),
		.i_ram_err(ram_err), .i_sw(sw), .o_led(led));

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Read pattern of the external RAM over every address bit
	function automatic wb_data_t ram_word(input wb_addr_t a);
		return {a[9:0], 22'h0} ^ {6'h0, a} ^ 32'hc3a5_0f1e;
	endfunction

	function automatic row_t mk(input logic host, input logic we, input wb_addr_t addr,
			input wb_data_t data, input wb_sel_t sel, input logic exp_err,
			input wb_data_t exp_data, input logic [4:0] flags);
		return '{host, we, addr, data, sel, exp_err, exp_data, flags};
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "check failed");
	endtask

	//////////////////////////////////////////////////////////////////////
	// External RAM model with random latency of 0 to 3 extra cycles
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		spur_d <= spur_arm;
		ram_ack <= spur_d;
		ram_err <= 1'b0;
		ram_stall <= (stall_left != 0);
		if (stall_left != 0 && ram_stb)
			stall_left <= stall_left - 1;
		if (busy)
		begin
			if (cnt == 2'd0)
			begin
				busy <= 1'b0;
				if (err_mode)
					ram_err <= 1'b1;
				else
				begin
					ram_ack <= 1'b1;
					ram_rdata <= ram_word(cap_addr);
				end
			end
			else
				cnt <= cnt - 2'd1;
		end
		else if (ram_cyc && ram_stb && !ram_stall)
		begin
			rng = xorshift(rng);
			busy <= 1'b1;
			cnt <= rng[1:0];
			cap_addr <= ram_addr;
			cap_data <= ram_wdata;
			cap_sel <= ram_sel;
			cap_we <= ram_we;
		end
	end

	// Non-blocking request drive on one master at the clock edge
	task automatic set_req(input logic host, input logic cyc, input logic stb, input row_t r);
		if (host)
		begin
			host_cyc <= cyc;
			host_stb <= stb;
			host_we <= r.we;
			host_addr <= r.addr;
			host_data <= r.data;
			host_sel <= r.sel;
		end
		else
		begin
			cpu_cyc <= cyc;
			cpu_stb <= stb;
			cpu_we <= r.we;
			cpu_addr <= r.addr;
			cpu_data <= r.data;
			cpu_sel <= r.sel;
		end
	endtask

	task automatic check_host_blocked(input logic en);
		if (en)
			assert (host_stall && !host_ack && !host_err)
			else fail_now($sformatf("ERR o_host_stall %h ack %h err %h while CPU owns bus",
				host_stall, host_ack, host_err));
	endtask

	// Returns at the accepting edge after dropping the strobe
	task automatic wait_accept(input row_t r, input logic chk_host);
		int n;
		logic st;
		n = 0;
		st = 1'b1;
		while (st)
		begin
			@(negedge clk);
			check_host_blocked(chk_host);
			st = r.host ? host_stall : cpu_stall;
			n++;
			if (n > TMO)
				fail_now("Timeout waiting for the request to be accepted");
		end
		if (r.flags[F_SPUR])
			spur_arm = 1'b1;
		@(posedge clk);
		set_req(r.host, 1'b1, 1'b0, r);
	endtask

	// Response check with fixed latency for on-chip and unmapped targets
	task automatic wait_resp(input row_t r, input logic chk_host);
		int lat;
		logic ack, err;
		wb_data_t d;
		string nm;
		lat = 0;
		ack = 1'b0;
		err = 1'b0;
		nm = r.host ? "host" : "cpu";
		while (!ack && !err)
		begin
			@(negedge clk);
			spur_arm = 1'b0;
			check_host_blocked(chk_host);
			ack = r.host ? host_ack : cpu_ack;
			err = r.host ? host_err : cpu_err;
			d = r.host ? host_rdata : cpu_rdata;
			lat++;
			if (lat > TMO)
				fail_now($sformatf("Timeout waiting for a response at address %h", r.addr));
		end
		assert (err == r.exp_err)
		else fail_now($sformatf("ERR o_%s_err got %h expected %h", nm, err, r.exp_err));
		if (!r.addr[`WBX_EXTRAM_BIT])
			assert (lat == 3)
			else fail_now($sformatf("ERR %s latency got %h expected %h", nm, lat, 3));
		if (!r.we && !r.exp_err)
			assert (d == r.exp_data)
			else fail_now($sformatf("ERR o_%s_data got %h expected %h", nm, d, r.exp_data));
	endtask

	task automatic run_row(input row_t r, input logic chk_host, input logic host_too,
			input row_t hr);
		@(negedge clk);
		err_mode = r.flags[F_RAM_ERR];
		stall_left = r.flags[F_STALL] ? 3 : 0;
		@(posedge clk);
		set_req(r.host, 1'b1, 1'b1, r);
		if (host_too)
			set_req(1'b1, 1'b1, 1'b1, hr);
		wait_accept(r, chk_host);
		wait_resp(r, chk_host);
		@(posedge clk);
		set_req(r.host, 1'b0, 1'b0, r);
		if (r.flags[F_LED])
			assert (led == r.data[3:0])
			else fail_now($sformatf("ERR o_led got %h expected %h", led, r.data[3:0]));
		if (r.flags[F_CAP])
		begin
			assert (cap_addr == r.addr)
			else fail_now($sformatf("ERR o_ram_addr got %h expected %h", cap_addr, r.addr));
			assert (cap_we == r.we)
			else fail_now($sformatf("ERR o_ram_we got %h expected %h", cap_we, r.we));
			assert (cap_sel == r.sel)
			else fail_now($sformatf("ERR o_ram_sel got %h expected %h", cap_sel, r.sel));
			assert (cap_data == r.data)
			else fail_now($sformatf("ERR o_ram_wdata got %h expected %h", cap_data, r.data));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table and sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		row_t hr;
		int n;
		cpu_cyc = 0;
		cpu_stb = 0;
		cpu_we = 0;
		cpu_addr = '0;
		cpu_data = '0;
		cpu_sel = '0;
		host_cyc = 0;
		host_stb = 0;
		host_we = 0;
		host_addr = '0;
		host_data = '0;
		host_sel = '0;
		ram_ack = 0;
		ram_stall = 0;
		ram_err = 0;
		ram_rdata = '0;
		busy = 0;
		spur_arm = 0;
		spur_d = 0;
		err_mode = 0;
		cnt = 0;
		stall_left = 0;
		rng = 32'h6aab;
		sw = 4'h9;
		// Block RAM byte lanes
		rows.push_back(mk(0, 1, 26'h400, 32'h11223344, 4'hf, 0, 0, 0));
		rows.push_back(mk(0, 1, 26'h400, 32'haabbccdd, 4'h5, 0, 0, 0));
		rows.push_back(mk(0, 0, 26'h400, 0, 4'hf, 0, 32'h11bb33dd, 0));
		rows.push_back(mk(0, 1, 26'h7ff, 32'h01020304, 4'hf, 0, 0, 0));
		rows.push_back(mk(0, 1, 26'h7ff, 32'hcafef00d, 4'h3, 0, 0, 0));
		rows.push_back(mk(0, 0, 26'h7ff, 0, 4'hf, 0, 32'h0102f00d, 0));
		// Board I/O
		rows.push_back(mk(0, 1, 26'h0, 32'h3c, 4'hf, 0, 0, 5'b01000));
		rows.push_back(mk(0, 0, 26'h1, 0, 4'hf, 0, 32'h9, 0));
		rows.push_back(mk(0, 0, 26'h0, 0, 4'hf, 0, 32'hc, 0));
		// Unmapped access then error address readback
		rows.push_back(mk(0, 0, 26'h800, 0, 4'hf, 1, 0, 0));
		rows.push_back(mk(0, 0, 26'h2, 0, 4'hf, 0, 32'h800, 0));
		// External RAM
		rows.push_back(mk(1, 1, 26'h2000123, 32'h55aa55aa, 4'h6, 0, 0, 5'b10000));
		rows.push_back(mk(0, 0, 26'h2000456, 0, 4'hf, 0, ram_word(26'h2000456), 5'b10000));
		rows.push_back(mk(0, 0, 26'h2001000, 0, 4'h9, 0, ram_word(26'h2001000), 5'b10010));
		rows.push_back(mk(0, 0, 26'h2000010, 0, 4'hf, 1, 0, 5'b10001));
		// Spurious second ack
		rows.push_back(mk(0, 0, 26'h400, 0, 4'hf, 1, 0, 5'b00100));
		rows.push_back(mk(0, 0, 26'h2, 0, 4'hf, 0, 32'h400, 0));
		n = rows.size();
		// Host waits behind three CPU requests
		rows.push_back(mk(0, 0, 26'h400, 0, 4'hf, 0, 32'h11bb33dd, 0));
		rows.push_back(mk(0, 1, 26'h401, 32'h77, 4'hf, 0, 0, 0));
		rows.push_back(mk(0, 0, 26'h401, 0, 4'hf, 0, 32'h77, 0));
		hr = mk(1, 0, 26'h7ff, 0, 4'hf, 0, 32'h0102f00d, 0);

		for (int i = 0; i < 200 && !rst_n; i++)
			@(posedge clk);
		assert (rst_n)
		else fail_now("Reset never released");
		repeat (2) @(posedge clk);
		assert (!cpu_ack && !cpu_err)
		else fail_now($sformatf("ERR o_cpu_ack %h o_cpu_err %h after reset expected 0",
			cpu_ack, cpu_err));
		assert (!host_ack && !host_err)
		else fail_now($sformatf("ERR o_host_ack %h o_host_err %h after reset expected 0",
			host_ack, host_err));
		assert (!ram_stb && !ram_cyc)
		else fail_now($sformatf("ERR o_ram_stb %h o_ram_cyc %h after reset expected 0",
			ram_stb, ram_cyc));
		assert (led == 4'h0)
		else fail_now($sformatf("ERR o_led after reset got %h expected %h", led, 4'h0));

		for (int i = 0; i < n; i++)
			run_row(rows[i], 1'b0, 1'b0, hr);
		for (int i = n; i < rows.size(); i++)
			run_row(rows[i], 1'b1, i == n, hr);
		wait_accept(hr, 1'b0);
		wait_resp(hr, 1'b0);
		@(posedge clk);
		set_req(1'b1, 1'b0, 1'b0, hr);
		repeat (2) @(posedge clk);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire
